// File: rtl/exuCfg.svh
// Execute stage configuration.
// Data path width, register address width and data memory depth shared
// by the RV64IM execute stage and its testbench.

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Integer register and data path width.
`define EXU_XLEN 64

// Register address width for a 32-entry register file.
`define EXU_REG_AW 5

// Data memory depth in 64-bit words (4 KiB).
`define EXU_DMEM_WORDS 512

`endif

// File: rtl/exuPkg.sv
// Execute stage types.
// Opcode enums and the decoded control struct that the decoder hands
// to the RV64IM execute stage each cycle.

`include "exuCfg.svh"

package exuPkg;

    // One code per ALU operation, multiply and divide included.
    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra,
        aluOr, aluAnd, aluPassB,
        aluAddw, aluSubw, aluSllw, aluSrlw, aluSraw,
        aluMul, aluMulh, aluMulhsu, aluMulhu, aluDiv, aluDivu, aluRem, aluRemu,
        aluMulw, aluDivw, aluDivuw, aluRemw, aluRemuw
    } aluOpE;

    // Next-address mode.
    typedef enum logic [2:0] {
        brNone           = 3'b000,
        brJal            = 3'b001,
        brJalr           = 3'b010,
        brTakenIfZero    = 3'b100,
        brTakenIfNonZero = 3'b101,
        brTakenIfLess    = 3'b110,
        brTakenIfNotLess = 3'b111
    } branchE;

    // Access size and extension, laid out like the load funct3 field.
    typedef enum logic [2:0] {
        memByte  = 3'b000,
        memHalf  = 3'b001,
        memWord  = 3'b010,
        memDword = 3'b011,
        memByteU = 3'b100,
        memHalfU = 3'b101,
        memWordU = 3'b110
    } memOpE;

    // ALU operand B source.
    typedef enum logic [1:0] {
        srcBRs2  = 2'b00,
        srcBImm  = 2'b01,
        srcBFour = 2'b10
    } srcBE;

    // Decoded control for one instruction.
    typedef struct packed {
        logic [`EXU_REG_AW-1:0] rd;
        logic [`EXU_REG_AW-1:0] rs1;
        logic [`EXU_REG_AW-1:0] rs2;
        logic                   regWen;
        logic                   srcAIsRs1;
        srcBE                   srcB;
        logic                   memToReg;
        logic                   memWen;
        aluOpE                  aluOp;
        branchE                 branch;
        memOpE                  memOp;
    } exuCtrlS;

endpackage

// File: rtl/regFile.sv
// Integer register file.
// Two combinational read ports and one clocked write port. Entry 0 is
// hardwired to zero and the whole array clears on reset.

`timescale 1ns/100ps

module regFile #(
    parameter int ADDR_W = 5,
    parameter int DATA_W = 64
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic [ADDR_W-1:0] raAddr,
    input  logic [ADDR_W-1:0] rbAddr,
    input  logic [ADDR_W-1:0] wAddr,
    input  logic [DATA_W-1:0] wData,
    input  logic              wen,
    output logic [DATA_W-1:0] raData,
    output logic [DATA_W-1:0] rbData
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] regs [DEPTH];

    // Writes to x0 are dropped so entry 0 keeps its reset value.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

    // Entry 0 is never written, so x0 reads as zero.
    assign raData = regs[raAddr];
    assign rbData = regs[rbAddr];

    // x0 storage stays zero across every write the stage commits.
    x0StaysZero: assert property (@(posedge clk) disable iff (!rstN) regs[0] == '0)
        else $error("register x0 holds a non-zero value");

endmodule

// File: rtl/alu.sv
// RV64IM arithmetic logic unit.
// Integer, shift, compare and logic operations, the 32-bit word forms,
// and multiply/divide with the RISC-V rules for zero and overflow.
// The zero flag feeds branch resolution.

`timescale 1ns/100ps

`include "exuCfg.svh"

module alu (
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    input  exuPkg::aluOpE        op,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 zero
);

    localparam int XLEN = `EXU_XLEN;
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic signed [XLEN-1:0]   aS;
    logic signed [XLEN-1:0]   bS;
    logic signed [31:0]       aW;
    logic signed [31:0]       bW;
    logic signed [2*XLEN-1:0] prodSS;
    logic signed [2*XLEN-1:0] prodSU;
    logic [2*XLEN-1:0]        prodUU;
    logic                     divZero;
    logic                     divOvf;
    logic                     divZeroW;
    logic                     divOvfW;

    // Word results are sign-extended to the full width.
    function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    assign aS = a;
    assign bS = b;
    assign aW = a[31:0];
    assign bW = b[31:0];

    // Full-width products for the high-half multiplies.
    assign prodSS = aS * bS;
    assign prodSU = aS * $signed({1'b0, b});
    assign prodUU = a * b;

    assign divZero  = (b == '0);
    assign divOvf   = (a == MIN_NEG) && (b == '1);
    assign divZeroW = (b[31:0] == '0);
    assign divOvfW  = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);

    always_comb begin
        result = '0;
        case (op)
            exuPkg::aluAdd:    result = a + b;
            exuPkg::aluSub:    result = a - b;
            exuPkg::aluSll:    result = a << b[5:0];
            exuPkg::aluSlt:    result = {{(XLEN-1){1'b0}}, aS < bS};
            exuPkg::aluSltu:   result = {{(XLEN-1){1'b0}}, a < b};
            exuPkg::aluXor:    result = a ^ b;
            exuPkg::aluSrl:    result = a >> b[5:0];
            exuPkg::aluSra:    result = aS >>> b[5:0];
            exuPkg::aluOr:     result = a | b;
            exuPkg::aluAnd:    result = a & b;
            exuPkg::aluPassB:  result = b;
            exuPkg::aluAddw:   result = sext32(a[31:0] + b[31:0]);
            exuPkg::aluSubw:   result = sext32(a[31:0] - b[31:0]);
            exuPkg::aluSllw:   result = sext32(a[31:0] << b[4:0]);
            exuPkg::aluSrlw:   result = sext32(a[31:0] >> b[4:0]);
            exuPkg::aluSraw:   result = sext32(aW >>> b[4:0]);
            exuPkg::aluMul:    result = prodUU[XLEN-1:0];
            exuPkg::aluMulh:   result = prodSS[2*XLEN-1:XLEN];
            exuPkg::aluMulhsu: result = prodSU[2*XLEN-1:XLEN];
            exuPkg::aluMulhu:  result = prodUU[2*XLEN-1:XLEN];
            exuPkg::aluMulw:   result = sext32(a[31:0] * b[31:0]);
            // Divide by zero gives all ones, overflow returns the dividend.
            exuPkg::aluDiv: begin
                if (divZero) result = '1;
                else if (divOvf) result = a;
                else result = aS / bS;
            end
            exuPkg::aluDivu:   result = divZero ? '1 : a / b;
            exuPkg::aluRem: begin
                if (divZero) result = a;
                else if (divOvf) result = '0;
                else result = aS % bS;
            end
            exuPkg::aluRemu:   result = divZero ? a : a % b;
            exuPkg::aluDivw: begin
                if (divZeroW) result = '1;
                else if (divOvfW) result = sext32(a[31:0]);
                else result = sext32(aW / bW);
            end
            exuPkg::aluDivuw: begin
                if (divZeroW) result = '1;
                else result = sext32(a[31:0] / b[31:0]);
            end
            exuPkg::aluRemw: begin
                if (divZeroW) result = sext32(a[31:0]);
                else if (divOvfW) result = '0;
                else result = sext32(aW % bW);
            end
            exuPkg::aluRemuw: begin
                if (divZeroW) result = sext32(a[31:0]);
                else result = sext32(a[31:0] % b[31:0]);
            end
            default:           result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: rtl/dataMem.sv
// Data memory.
// Doubleword array with combinational, sized loads that sign- or
// zero-extend, and byte-masked stores on the rising clock edge.

`timescale 1ns/100ps

`include "exuCfg.svh"

module dataMem (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [`EXU_XLEN-1:0] addr,
    input  logic [`EXU_XLEN-1:0] wData,
    input  logic                 wen,
    input  exuPkg::memOpE        op,
    output logic [`EXU_XLEN-1:0] rData
);

    localparam int XLEN  = `EXU_XLEN;
    localparam int WORDS = `EXU_DMEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    logic [XLEN-1:0]  mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic [2:0]       byteOff;
    logic [XLEN-1:0]  lineSh;
    logic [7:0]       sizeMask;
    logic [2:0]       alignMask;
    logic [7:0]       byteEn;
    logic [XLEN-1:0]  wDataSh;

    assign idx     = addr[3 +: IDX_W];
    assign byteOff = addr[2:0];

    // Addressed lane moved down to bit 0.
    assign lineSh = mem[idx] >> {byteOff, 3'b000};

    always_comb begin
        case (op)
            exuPkg::memByte:  rData = {{(XLEN-8){lineSh[7]}}, lineSh[7:0]};
            exuPkg::memHalf:  rData = {{(XLEN-16){lineSh[15]}}, lineSh[15:0]};
            exuPkg::memWord:  rData = {{(XLEN-32){lineSh[31]}}, lineSh[31:0]};
            exuPkg::memByteU: rData = {{(XLEN-8){1'b0}}, lineSh[7:0]};
            exuPkg::memHalfU: rData = {{(XLEN-16){1'b0}}, lineSh[15:0]};
            exuPkg::memWordU: rData = {{(XLEN-32){1'b0}}, lineSh[31:0]};
            default:          rData = lineSh;
        endcase
    end

    // Byte lanes and alignment per access size.
    always_comb begin
        case (op)
            exuPkg::memByte, exuPkg::memByteU: begin
                sizeMask  = 8'h01;
                alignMask = 3'b000;
            end
            exuPkg::memHalf, exuPkg::memHalfU: begin
                sizeMask  = 8'h03;
                alignMask = 3'b001;
            end
            exuPkg::memWord, exuPkg::memWordU: begin
                sizeMask  = 8'h0f;
                alignMask = 3'b011;
            end
            default: begin
                sizeMask  = 8'hff;
                alignMask = 3'b111;
            end
        endcase
    end

    assign byteEn  = sizeMask << byteOff;
    assign wDataSh = wData << {byteOff, 3'b000};

    // Stores are held off while reset is asserted.
    always_ff @(posedge clk) begin
        if (rstN && wen) begin
            for (int i = 0; i < XLEN / 8; i++) begin
                if (byteEn[i]) mem[idx][i*8 +: 8] <= wDataSh[i*8 +: 8];
            end
        end
    end

    // The decoder only issues naturally aligned stores.
    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        wen |-> ((addr[2:0] & alignMask) == 3'b000))
        else $error("misaligned store to 0x%h", addr);

endmodule

// File: rtl/nextAddr.sv
// Next-address unit.
// Resolves branches and jumps from the ALU flags and picks the base and
// offset of the next pc: pc+4, pc+imm or rs1+imm, with bit 0 cleared.

`timescale 1ns/100ps

`include "exuCfg.svh"

module nextAddr (
    input  logic                 zero,
    input  logic                 resLsb,
    input  exuPkg::branchE       branch,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] busA,
    output logic [`EXU_XLEN-1:0] dnpc
);

    localparam int XLEN = `EXU_XLEN;

    logic            baseIsBusA;
    logic            offsetIsImm;
    logic [XLEN-1:0] sum;

    // Base pc or rs1, offset four or imm.
    always_comb begin
        baseIsBusA  = 1'b0;
        offsetIsImm = 1'b0;
        case (branch)
            exuPkg::brJal:            offsetIsImm = 1'b1;
            exuPkg::brJalr: begin
                baseIsBusA  = 1'b1;
                offsetIsImm = 1'b1;
            end
            exuPkg::brTakenIfZero:    offsetIsImm = zero;
            exuPkg::brTakenIfNonZero: offsetIsImm = ~zero;
            exuPkg::brTakenIfLess:    offsetIsImm = resLsb;
            exuPkg::brTakenIfNotLess: offsetIsImm = zero | ~resLsb;
            default:                  offsetIsImm = 1'b0;
        endcase
    end

    // jalr targets with an odd sum still come out even.
    assign sum  = (baseIsBusA ? busA : pc) + (offsetIsImm ? imm : XLEN'(4));
    assign dnpc = {sum[XLEN-1:1], 1'b0};

endmodule

// File: rtl/exu.sv
// RV64IM single-cycle execute stage.
// Reads operands from the register file, runs the ALU, accesses data
// memory, writes back and resolves the next pc in one cycle. wbData is
// the value offered to the register file and serves as a commit trace.

`timescale 1ns/100ps

`include "exuCfg.svh"

module exu (
    input  logic                 clk,
    input  logic                 rstN,
    input  exuPkg::exuCtrlS      ctrl,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    output logic [`EXU_XLEN-1:0] dnpc,
    output logic [`EXU_XLEN-1:0] wbData
);

    localparam int XLEN = `EXU_XLEN;

    logic [XLEN-1:0] busA;
    logic [XLEN-1:0] busB;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] loadData;
    logic            zero;

    regFile #(
        .ADDR_W(`EXU_REG_AW),
        .DATA_W(XLEN)
    ) u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .raAddr (ctrl.rs1),
        .rbAddr (ctrl.rs2),
        .wAddr  (ctrl.rd),
        .wData  (wbData),
        .wen    (ctrl.regWen),
        .raData (busA),
        .rbData (busB)
    );

    // Operand A is pc for auipc and jal link values.
    assign opA = ctrl.srcAIsRs1 ? busA : pc;

    always_comb begin
        case (ctrl.srcB)
            exuPkg::srcBImm:  opB = imm;
            exuPkg::srcBFour: opB = XLEN'(4);
            default:          opB = busB;
        endcase
    end

    alu u_alu (
        .a      (opA),
        .b      (opB),
        .op     (ctrl.aluOp),
        .result (aluRes),
        .zero   (zero)
    );

    dataMem u_dataMem (
        .clk   (clk),
        .rstN  (rstN),
        .addr  (aluRes),
        .wData (busB),
        .wen   (ctrl.memWen),
        .op    (ctrl.memOp),
        .rData (loadData)
    );

    assign wbData = ctrl.memToReg ? loadData : aluRes;

    nextAddr u_nextAddr (
        .zero   (zero),
        .resLsb (aluRes[0]),
        .branch (ctrl.branch),
        .pc     (pc),
        .imm    (imm),
        .busA   (busA),
        .dnpc   (dnpc)
    );

endmodule

// File: testbench/exuTb.sv
// Testbench for the RV64IM execute stage.
// Runs a short hand-checked program from a table and compares the next pc
// and the writeback data of every instruction against expected values.

`timescale 1ns/100ps

`include "exuCfg.svh"

module exuTb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    typedef logic [`EXU_XLEN-1:0] wordT;

    // One instruction with its expected results.
    typedef struct packed {
        exuPkg::exuCtrlS ctrl;
        wordT            pc;
        wordT            imm;
        wordT            expDnpc;
        wordT            expWb;
        logic            checkWb;
    } rowS;

    logic            clk;
    logic            rstN;
    exuPkg::exuCtrlS ctrl;
    wordT            pc;
    wordT            imm;
    wordT            dnpc;
    wordT            wbData;

    rowS  rows[$];
    wordT progPc;
    bit   tableReady;

    exu u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .pc     (pc),
        .imm    (imm),
        .dnpc   (dnpc),
        .wbData (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkEq(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic exuPkg::exuCtrlS makeCtrl(
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic regWen, input logic srcAIsRs1, input exuPkg::srcBE srcB,
        input logic memToReg, input logic memWen, input exuPkg::aluOpE op,
        input exuPkg::branchE br, input exuPkg::memOpE memOp);
        exuPkg::exuCtrlS c;
        c.rd        = rd;
        c.rs1       = rs1;
        c.rs2       = rs2;
        c.regWen    = regWen;
        c.srcAIsRs1 = srcAIsRs1;
        c.srcB      = srcB;
        c.memToReg  = memToReg;
        c.memWen    = memWen;
        c.aluOp     = op;
        c.branch    = br;
        c.memOp     = memOp;
        return c;
    endfunction

    // The program counter follows the expected next pc of each row.
    task automatic pushRow(input exuPkg::exuCtrlS c, input wordT immV, input wordT expDnpc,
                           input wordT expWb, input logic checkWb);
        rowS r;
        r.ctrl    = c;
        r.pc      = progPc;
        r.imm     = immV;
        r.expDnpc = expDnpc;
        r.expWb   = expWb;
        r.checkWb = checkWb;
        rows.push_back(r);
        progPc = expDnpc;
    endtask

    task automatic regOp(input exuPkg::aluOpE op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input wordT expWb);
        pushRow(makeCtrl(rd, rs1, rs2, 1'b1, 1'b1, exuPkg::srcBRs2, 1'b0, 1'b0, op,
                         exuPkg::brNone, exuPkg::memDword), '0, progPc + 4, expWb, 1'b1);
    endtask

    task automatic immOp(input exuPkg::aluOpE op, input logic [4:0] rd, input logic [4:0] rs1,
                         input wordT immV, input wordT expWb);
        pushRow(makeCtrl(rd, rs1, 5'd0, 1'b1, 1'b1, exuPkg::srcBImm, 1'b0, 1'b0, op,
                         exuPkg::brNone, exuPkg::memDword), immV, progPc + 4, expWb, 1'b1);
    endtask

    task automatic store(input exuPkg::memOpE memOp, input logic [4:0] rs1,
                         input logic [4:0] rs2, input wordT immV);
        pushRow(makeCtrl(5'd0, rs1, rs2, 1'b0, 1'b1, exuPkg::srcBImm, 1'b0, 1'b1,
                         exuPkg::aluAdd, exuPkg::brNone, memOp), immV, progPc + 4, '0, 1'b0);
    endtask

    task automatic load(input exuPkg::memOpE memOp, input logic [4:0] rd, input logic [4:0] rs1,
                        input wordT immV, input wordT expWb);
        pushRow(makeCtrl(rd, rs1, 5'd0, 1'b1, 1'b1, exuPkg::srcBImm, 1'b1, 1'b0,
                         exuPkg::aluAdd, exuPkg::brNone, memOp), immV, progPc + 4, expWb, 1'b1);
    endtask

    task automatic condBranch(input exuPkg::branchE br, input exuPkg::aluOpE op,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input wordT immV, input logic taken);
        pushRow(makeCtrl(5'd0, rs1, rs2, 1'b0, 1'b1, exuPkg::srcBRs2, 1'b0, 1'b0, op, br,
                         exuPkg::memDword), immV, taken ? progPc + immV : progPc + 4, '0, 1'b0);
    endtask

    // Link value comes from pc plus the constant four.
    task automatic jal(input logic [4:0] rd, input wordT immV);
        pushRow(makeCtrl(rd, 5'd0, 5'd0, 1'b1, 1'b0, exuPkg::srcBFour, 1'b0, 1'b0,
                         exuPkg::aluAdd, exuPkg::brJal, exuPkg::memDword),
                immV, progPc + immV, progPc + 4, 1'b1);
    endtask

    task automatic jalr(input logic [4:0] rd, input logic [4:0] rs1, input wordT immV,
                        input wordT expDnpc);
        pushRow(makeCtrl(rd, rs1, 5'd0, 1'b1, 1'b0, exuPkg::srcBFour, 1'b0, 1'b0,
                         exuPkg::aluAdd, exuPkg::brJalr, exuPkg::memDword),
                immV, expDnpc, progPc + 4, 1'b1);
    endtask

    task automatic buildProgram();
        progPc = 64'h1000;
        immOp(exuPkg::aluAdd, 0, 0, 64'h5, 64'h5);
        regOp(exuPkg::aluAdd, 1, 0, 0, 64'h0);
        immOp(exuPkg::aluAdd, 1, 0, 64'h64, 64'h64);
        immOp(exuPkg::aluAdd, 2, 0, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF9);
        immOp(exuPkg::aluPassB, 3, 0, 64'h1234_5000, 64'h1234_5000);
        regOp(exuPkg::aluAdd, 4, 1, 2, 64'h5D);
        regOp(exuPkg::aluSub, 5, 1, 2, 64'h6B);
        immOp(exuPkg::aluAdd, 6, 0, 64'h4, 64'h4);
        regOp(exuPkg::aluSll, 7, 1, 6, 64'h640);
        regOp(exuPkg::aluSrl, 8, 2, 6, 64'h0FFF_FFFF_FFFF_FFFF);
        regOp(exuPkg::aluSra, 9, 2, 6, 64'hFFFF_FFFF_FFFF_FFFF);
        regOp(exuPkg::aluSlt, 10, 2, 1, 64'h1);
        regOp(exuPkg::aluSltu, 11, 2, 1, 64'h0);
        regOp(exuPkg::aluXor, 12, 1, 3, 64'h1234_5064);
        regOp(exuPkg::aluAnd, 13, 1, 2, 64'h60);
        regOp(exuPkg::aluOr, 14, 2, 6, 64'hFFFF_FFFF_FFFF_FFFD);
        // Word forms sign-extend bit 31 of the 32-bit result.
        immOp(exuPkg::aluPassB, 16, 0, 64'h7FFF_F000, 64'h7FFF_F000);
        regOp(exuPkg::aluAddw, 17, 16, 16, 64'hFFFF_FFFF_FFFF_E000);
        regOp(exuPkg::aluSubw, 18, 1, 16, 64'hFFFF_FFFF_8000_1064);
        regOp(exuPkg::aluSllw, 19, 16, 6, 64'hFFFF_FFFF_FFFF_0000);
        regOp(exuPkg::aluSrlw, 20, 2, 6, 64'h0000_0000_0FFF_FFFF);
        regOp(exuPkg::aluSraw, 21, 17, 6, 64'hFFFF_FFFF_FFFF_FE00);
        regOp(exuPkg::aluMul, 22, 1, 2, 64'hFFFF_FFFF_FFFF_FD44);
        regOp(exuPkg::aluMulh, 23, 1, 2, 64'hFFFF_FFFF_FFFF_FFFF);
        regOp(exuPkg::aluMulhu, 24, 1, 2, 64'h63);
        regOp(exuPkg::aluDiv, 25, 1, 2, 64'hFFFF_FFFF_FFFF_FFF2);
        regOp(exuPkg::aluRem, 26, 1, 2, 64'h2);
        regOp(exuPkg::aluDiv, 27, 1, 0, 64'hFFFF_FFFF_FFFF_FFFF);
        regOp(exuPkg::aluRem, 28, 1, 0, 64'h64);
        immOp(exuPkg::aluAdd, 29, 0, 64'h1, 64'h1);
        immOp(exuPkg::aluSll, 29, 29, 64'd63, 64'h8000_0000_0000_0000);
        regOp(exuPkg::aluDiv, 30, 29, 9, 64'h8000_0000_0000_0000);
        regOp(exuPkg::aluRem, 31, 29, 9, 64'h0);
        // Two doublewords at 0x100, the second one patched by sw, sh and sb.
        immOp(exuPkg::aluAdd, 27, 0, 64'h100, 64'h100);
        store(exuPkg::memDword, 27, 18, 64'h0);
        store(exuPkg::memDword, 27, 8, 64'h8);
        store(exuPkg::memWord, 27, 3, 64'hC);
        store(exuPkg::memHalf, 27, 12, 64'hA);
        store(exuPkg::memByte, 27, 2, 64'h9);
        load(exuPkg::memByte, 11, 27, 64'h9, 64'hFFFF_FFFF_FFFF_FFF9);
        load(exuPkg::memByteU, 11, 27, 64'h9, 64'hF9);
        load(exuPkg::memHalf, 11, 27, 64'h8, 64'hFFFF_FFFF_FFFF_F9FF);
        load(exuPkg::memHalfU, 11, 27, 64'h8, 64'hF9FF);
        load(exuPkg::memHalf, 11, 27, 64'hA, 64'h5064);
        load(exuPkg::memWord, 11, 27, 64'h8, 64'h5064_F9FF);
        load(exuPkg::memWord, 11, 27, 64'h0, 64'hFFFF_FFFF_8000_1064);
        load(exuPkg::memWordU, 11, 27, 64'h0, 64'h8000_1064);
        load(exuPkg::memWordU, 11, 27, 64'hC, 64'h1234_5000);
        load(exuPkg::memDword, 11, 27, 64'h8, 64'h1234_5000_5064_F9FF);
        load(exuPkg::memDword, 11, 27, 64'h0, 64'hFFFF_FFFF_8000_1064);
        condBranch(exuPkg::brTakenIfZero, exuPkg::aluSub, 1, 1, 64'h10, 1'b1);
        condBranch(exuPkg::brTakenIfZero, exuPkg::aluSub, 1, 2, 64'h10, 1'b0);
        condBranch(exuPkg::brTakenIfNonZero, exuPkg::aluSub, 1, 2, 64'h8, 1'b1);
        condBranch(exuPkg::brTakenIfNonZero, exuPkg::aluSub, 6, 6, 64'h8, 1'b0);
        condBranch(exuPkg::brTakenIfLess, exuPkg::aluSlt, 2, 1, 64'h20, 1'b1);
        condBranch(exuPkg::brTakenIfLess, exuPkg::aluSlt, 1, 2, 64'h20, 1'b0);
        condBranch(exuPkg::brTakenIfNotLess, exuPkg::aluSlt, 1, 2, 64'hFFFF_FFFF_FFFF_FFF4, 1'b1);
        condBranch(exuPkg::brTakenIfNotLess, exuPkg::aluSlt, 2, 1, 64'hFFFF_FFFF_FFFF_FFF4, 1'b0);
        condBranch(exuPkg::brTakenIfNotLess, exuPkg::aluSlt, 6, 6, 64'h18, 1'b1);
        condBranch(exuPkg::brTakenIfLess, exuPkg::aluSltu, 1, 2, 64'h20, 1'b1);
        condBranch(exuPkg::brTakenIfLess, exuPkg::aluSltu, 2, 1, 64'h20, 1'b0);
        condBranch(exuPkg::brTakenIfNotLess, exuPkg::aluSltu, 2, 1, 64'h10, 1'b1);
        condBranch(exuPkg::brTakenIfNotLess, exuPkg::aluSltu, 1, 2, 64'h10, 1'b0);
        jal(1, 64'h40);
        // x6 + 7 is odd, target rounds down to 0xA.
        jalr(5, 6, 64'h7, 64'hA);
    endtask

    initial begin
        int limitNs;
        wait (tableReady);
        limitNs = 2 * (RESET_CYCLES + 1 + rows.size()) * CLK_PERIOD;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rowS r;
        rstN = 1'b0;
        ctrl = '0;
        pc   = '0;
        imm  = '0;
        buildProgram();
        tableReady = 1'b1;

        // Registers read zero while reset is held.
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            ctrl = makeCtrl(5'(i + 1), 5'(2 * i), 5'(2 * i + 1), 1'b1, 1'b1, exuPkg::srcBRs2,
                            1'b0, 1'b0, exuPkg::aluAdd, exuPkg::brNone, exuPkg::memDword);
            #1;
            checkEq(wbData, '0, $sformatf("reset cycle %0d wbData", i));
        end
        @(negedge clk);
        ctrl = '0;
        rstN = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(negedge clk);
            ctrl = r.ctrl;
            pc   = r.pc;
            imm  = r.imm;
            #1;
            checkEq(dnpc, r.expDnpc, $sformatf("row %0d pc 0x%h dnpc", i, r.pc));
            if (r.checkWb) begin
                checkEq(wbData, r.expWb, $sformatf("row %0d pc 0x%h wbData", i, r.pc));
            end
        end
        @(negedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: Bender.yml
package:
  name: exu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/exuPkg.sv
      - rtl/regFile.sv
      - rtl/alu.sv
      - rtl/dataMem.sv
      - rtl/nextAddr.sv
      - rtl/exu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/exuTb.sv

// File: all.f
+incdir+rtl
rtl/exuPkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/nextAddr.sv
rtl/exu.sv
testbench/exuTb.sv
